// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_jpeg_huffman_encode
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(BUILD_DIR)

// ==== rtl/bit_packer.sv ====
module bit_packer import huff_pkg::*; (
    input  logic        clock,
    input  logic        nreset,
    input  logic        start,
    input  logic        pack_write,
    input  logic        pack_is_dc,
    input  code_t       pack_value,
    input  category_t   pack_category,
    input  logic        pack_last,
    input  code_t       dc_code,
    input  stored_len_t dc_len,
    input  code_t       ac_code,
    input  stored_len_t ac_len,
    output logic        output_wren,
    output out_data_t   output_data,
    output out_len_t    output_length,
    output logic        busy
);

    code_t    code;
    out_len_t code_len;

    always_comb begin
        if (pack_is_dc) begin
            code     = dc_code;
            code_len = out_len_t'(dc_len) + 1'b1;
        end else begin
            code     = ac_code;
            code_len = out_len_t'(ac_len) + 1'b1;
        end
    end

    // code first, coded value right above it
    assign output_data   = out_data_t'(code) | (out_data_t'(pack_value) << code_len);
    assign output_length = code_len + out_len_t'(pack_category);
    assign output_wren   = pack_write;

    always_ff @(posedge clock) begin
        if (nreset) begin
            busy <= 1'b0;
        end else if (pack_write && pack_last) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end
    end

endmodule

// ==== rtl/coefficient_stage.sv ====
module coefficient_stage import huff_pkg::*; (
    input  logic      clock,
    input  logic      nreset,
    input  logic      start,
    input  coeff_t    src_data_in,
    input  logic      rollback,
    input  index_t    zero_run,
    output index_t    fetch_addr,
    output logic      item_valid,
    output index_t    item_index,
    output code_t     coded_value,
    output category_t category
);

    index_t    fetch_index;
    logic      fetch_active;
    index_t    data_index;
    logic      data_valid;
    coeff_t    dc_prev;
    coeff_t    diff;
    coeff_t    magnitude;
    code_t     raw_value;
    category_t diff_category;
    code_t     diff_code;

    //////////////////////////////
    // fetch
    always_ff @(posedge clock) begin
        if (nreset) begin
            fetch_index  <= '0;
            fetch_active <= 1'b0;
        end else if (rollback) begin
            // resume right after the sixteen zeros that the zrl symbol covers
            fetch_index  <= item_index - (zero_run - zrl_run);
            fetch_active <= 1'b1;
        end else if (fetch_active) begin
            fetch_index <= fetch_index + 1'b1;
            if (fetch_index == last_index) begin
                fetch_active <= 1'b0;
            end
        end else if (start) begin
            fetch_active <= 1'b1;
        end
    end

    assign fetch_addr = fetch_index;

    //////////////////////////////
    // memory word arrives, code it
    always_ff @(posedge clock) begin
        if (nreset) begin
            data_valid <= 1'b0;
            item_valid <= 1'b0;
            dc_prev    <= '0;
        end else begin
            // a rollback kills both items still in flight
            data_valid <= fetch_active && !rollback;
            item_valid <= data_valid && !rollback;
            if (data_valid && !rollback && data_index == '0) begin
                dc_prev <= src_data_in;
            end
        end
    end

    always_comb begin
        // dc is sent as the difference to the previous block
        diff = (data_index == '0) ? src_data_in - dc_prev : src_data_in;
        magnitude = (diff < 0) ? -diff : diff;
        diff_category = '0;
        for (int b = 0; b < coeff_bits - 1; b++) begin
            if (magnitude[b]) begin
                diff_category = category_t'(b + 1);
            end
        end
        // negatives go out as value minus one
        raw_value = (diff < 0) ? code_t'(diff - 1'b1) : code_t'(diff);
        diff_code = raw_value & ~(code_t'('1) << diff_category);
    end

    always_ff @(posedge clock) begin
        data_index  <= fetch_index;
        item_index  <= data_index;
        coded_value <= diff_code;
        category    <= diff_category;
    end

    // both code tables end early, the ac one at category 4
    a_category_in_table: assert property (@(posedge clock) disable iff (nreset)
        item_valid |->
            category <= ((item_index == '0) ? dc_max_category : max_ac_category));

endmodule

// ==== rtl/huff_pkg.sv ====
package huff_pkg;

    //////////////////////////////
    // widths
    localparam int index_bits      = 6;
    localparam int coeff_bits      = 16;
    localparam int code_bits       = 16;
    localparam int category_bits   = 4;
    localparam int stored_len_bits = 4;
    localparam int symbol_bits     = 8;
    localparam int out_len_bits    = 6;
    localparam int out_data_bits   = 32;

    typedef logic [index_bits-1:0]        index_t;
    typedef logic signed [coeff_bits-1:0] coeff_t;
    // codes and coded values sit in the low bits, first bit at bit 0
    typedef logic [code_bits-1:0]         code_t;
    typedef logic [category_bits-1:0]     category_t;
    // code length minus one, a code is never empty
    typedef logic [stored_len_bits-1:0]   stored_len_t;
    // run in the high nibble, size in the low nibble
    typedef logic [symbol_bits-1:0]       symbol_t;
    typedef logic [out_len_bits-1:0]      out_len_t;
    typedef logic [out_data_bits-1:0]     out_data_t;

    // one table word as held in block ram
    typedef struct packed {
        stored_len_t len;
        code_t       code;
    } rom_entry_t;

    //////////////////////////////
    // block and table limits
    localparam index_t    last_index      = 6'd63;
    localparam index_t    zrl_run         = 6'd16;
    localparam category_t dc_max_category = 4'd11;
    localparam category_t max_ac_category = 4'd4;

    // special ac symbols
    localparam symbol_t zrl_symbol = 8'hf0;
    localparam symbol_t eob_symbol = 8'h00;

endpackage

// ==== rtl/huffman_code_rom.sv ====
module huffman_code_rom import huff_pkg::*; (
    input  logic        clock,
    input  category_t   dc_category,
    input  symbol_t     ac_symbol,
    output code_t       dc_code,
    output stored_len_t dc_len,
    output code_t       ac_code,
    output stored_len_t ac_len
);

    rom_entry_t dc_word;
    rom_entry_t ac_word;

    // luminance dc table, indexed by category
    always_ff @(posedge clock) begin
        case (dc_category)
            4'h0: dc_word <= {4'h1, 16'h0000};
            4'h1: dc_word <= {4'h2, 16'h0002};
            4'h2: dc_word <= {4'h2, 16'h0003};
            4'h3: dc_word <= {4'h2, 16'h0004};
            4'h4: dc_word <= {4'h2, 16'h0005};
            4'h5: dc_word <= {4'h2, 16'h0006};
            4'h6: dc_word <= {4'h3, 16'h000e};
            4'h7: dc_word <= {4'h4, 16'h001e};
            4'h8: dc_word <= {4'h5, 16'h003e};
            4'h9: dc_word <= {4'h6, 16'h007e};
            4'ha: dc_word <= {4'h7, 16'h00fe};
            4'hb: dc_word <= {4'h8, 16'h01fe};
            default: dc_word <= {4'hf, 16'h0000};
        endcase
    end

    // luminance ac table, sizes 1 to 4 only
    always_ff @(posedge clock) begin
        case (ac_symbol)
            8'h00: ac_word <= {4'h3, 16'h000a};
            8'h01: ac_word <= {4'h1, 16'h0000};
            8'h02: ac_word <= {4'h1, 16'h0001};
            8'h03: ac_word <= {4'h2, 16'h0004};
            8'h04: ac_word <= {4'h3, 16'h000b};
            8'h11: ac_word <= {4'h3, 16'h000c};
            8'h12: ac_word <= {4'h4, 16'h001b};
            8'h13: ac_word <= {4'h6, 16'h0079};
            8'h14: ac_word <= {4'h8, 16'h01f6};
            8'h21: ac_word <= {4'h4, 16'h001c};
            8'h22: ac_word <= {4'h7, 16'h00f9};
            8'h23: ac_word <= {4'h9, 16'h03f7};
            8'h24: ac_word <= {4'hb, 16'h0ff4};
            8'h31: ac_word <= {4'h5, 16'h003a};
            8'h32: ac_word <= {4'h8, 16'h01f7};
            8'h33: ac_word <= {4'hb, 16'h0ff5};
            8'h34: ac_word <= {4'hf, 16'hff8f};
            8'h41: ac_word <= {4'h5, 16'h003b};
            8'h42: ac_word <= {4'h9, 16'h03f8};
            8'h43: ac_word <= {4'hf, 16'hff96};
            8'h44: ac_word <= {4'hf, 16'hff97};
            8'h51: ac_word <= {4'h6, 16'h007a};
            8'h52: ac_word <= {4'ha, 16'h07f7};
            8'h53: ac_word <= {4'hf, 16'hff9e};
            8'h54: ac_word <= {4'hf, 16'hff9f};
            8'h61: ac_word <= {4'h6, 16'h007b};
            8'h62: ac_word <= {4'hb, 16'h0ff6};
            8'h63: ac_word <= {4'hf, 16'hffa6};
            8'h64: ac_word <= {4'hf, 16'hffa7};
            8'h71: ac_word <= {4'h7, 16'h00fa};
            8'h72: ac_word <= {4'hb, 16'h0ff7};
            8'h73: ac_word <= {4'hf, 16'hffae};
            8'h74: ac_word <= {4'hf, 16'hffaf};
            8'h81: ac_word <= {4'h8, 16'h01f8};
            8'h82: ac_word <= {4'he, 16'h7fc0};
            8'h83: ac_word <= {4'hf, 16'hffb6};
            8'h84: ac_word <= {4'hf, 16'hffb7};
            8'h91: ac_word <= {4'h8, 16'h01f9};
            8'h92: ac_word <= {4'hf, 16'hffbe};
            8'h93: ac_word <= {4'hf, 16'hffbf};
            8'h94: ac_word <= {4'hf, 16'hffc0};
            8'ha1: ac_word <= {4'h8, 16'h01fa};
            8'ha2: ac_word <= {4'hf, 16'hffc7};
            8'ha3: ac_word <= {4'hf, 16'hffc8};
            8'ha4: ac_word <= {4'hf, 16'hffc9};
            8'hb1: ac_word <= {4'h9, 16'h03f9};
            8'hb2: ac_word <= {4'hf, 16'hffd0};
            8'hb3: ac_word <= {4'hf, 16'hffd1};
            8'hb4: ac_word <= {4'hf, 16'hffd2};
            8'hc1: ac_word <= {4'h9, 16'h03fa};
            8'hc2: ac_word <= {4'hf, 16'hffd9};
            8'hc3: ac_word <= {4'hf, 16'hffda};
            8'hc4: ac_word <= {4'hf, 16'hffdb};
            8'hd1: ac_word <= {4'ha, 16'h07f8};
            8'hd2: ac_word <= {4'hf, 16'hffe2};
            8'hd3: ac_word <= {4'hf, 16'hffe3};
            8'hd4: ac_word <= {4'hf, 16'hffe4};
            8'he1: ac_word <= {4'hf, 16'hffeb};
            8'he2: ac_word <= {4'hf, 16'hffec};
            8'he3: ac_word <= {4'hf, 16'hffed};
            8'he4: ac_word <= {4'hf, 16'hffee};
            8'hf0: ac_word <= {4'ha, 16'h07f9};
            8'hf1: ac_word <= {4'hf, 16'hfff5};
            8'hf2: ac_word <= {4'hf, 16'hfff6};
            8'hf3: ac_word <= {4'hf, 16'hfff7};
            8'hf4: ac_word <= {4'hf, 16'hfff8};
            default: ac_word <= {4'hf, 16'h0000};
        endcase
    end

    assign dc_code = dc_word.code;
    assign dc_len  = dc_word.len;
    assign ac_code = ac_word.code;
    assign ac_len  = ac_word.len;

endmodule

// ==== rtl/jpeg_huffman_encode.sv ====
module jpeg_huffman_encode import huff_pkg::*; (
    input  logic      clock,
    input  logic      nreset,
    input  logic      start,
    input  coeff_t    src_data_in,
    output index_t    fetch_addr,
    output logic      output_wren,
    output out_data_t output_data,
    output out_len_t  output_length,
    output logic      busy
);

    logic        item_valid;
    index_t      item_index;
    code_t       coded_value;
    category_t   category;
    logic        rollback;
    index_t      zero_run;
    category_t   dc_category;
    symbol_t     ac_symbol;
    code_t       dc_code;
    stored_len_t dc_len;
    code_t       ac_code;
    stored_len_t ac_len;
    logic        pack_write;
    logic        pack_is_dc;
    code_t       pack_value;
    category_t   pack_category;
    logic        pack_last;

    coefficient_stage i_coefficient_stage (
        .clock       (clock),
        .nreset      (nreset),
        .start       (start),
        .src_data_in (src_data_in),
        .rollback    (rollback),
        .zero_run    (zero_run),
        .fetch_addr  (fetch_addr),
        .item_valid  (item_valid),
        .item_index  (item_index),
        .coded_value (coded_value),
        .category    (category)
    );

    run_length_stage i_run_length_stage (
        .clock         (clock),
        .nreset        (nreset),
        .item_valid    (item_valid),
        .item_index    (item_index),
        .coded_value   (coded_value),
        .category      (category),
        .rollback      (rollback),
        .zero_run      (zero_run),
        .dc_category   (dc_category),
        .ac_symbol     (ac_symbol),
        .pack_write    (pack_write),
        .pack_is_dc    (pack_is_dc),
        .pack_value    (pack_value),
        .pack_category (pack_category),
        .pack_last     (pack_last)
    );

    huffman_code_rom i_huffman_code_rom (
        .clock       (clock),
        .dc_category (dc_category),
        .ac_symbol   (ac_symbol),
        .dc_code     (dc_code),
        .dc_len      (dc_len),
        .ac_code     (ac_code),
        .ac_len      (ac_len)
    );

    bit_packer i_bit_packer (
        .clock         (clock),
        .nreset        (nreset),
        .start         (start),
        .pack_write    (pack_write),
        .pack_is_dc    (pack_is_dc),
        .pack_value    (pack_value),
        .pack_category (pack_category),
        .pack_last     (pack_last),
        .dc_code       (dc_code),
        .dc_len        (dc_len),
        .ac_code       (ac_code),
        .ac_len        (ac_len),
        .output_wren   (output_wren),
        .output_data   (output_data),
        .output_length (output_length),
        .busy          (busy)
    );

    // one block at a time
    a_start_when_idle: assert property (@(posedge clock) disable iff (nreset)
        start |-> !busy);

endmodule

// ==== rtl/run_length_stage.sv ====
module run_length_stage import huff_pkg::*; (
    input  logic      clock,
    input  logic      nreset,
    input  logic      item_valid,
    input  index_t    item_index,
    input  code_t     coded_value,
    input  category_t category,
    output logic      rollback,
    output index_t    zero_run,
    output category_t dc_category,
    output symbol_t   ac_symbol,
    output logic      pack_write,
    output logic      pack_is_dc,
    output code_t     pack_value,
    output category_t pack_category,
    output logic      pack_last
);

    logic is_dc;
    logic is_last;
    logic nonzero;

    assign is_dc   = (item_index == '0);
    assign is_last = (item_index == last_index);
    assign nonzero = (category != '0);

    // a nonzero value after 16 or more zeros sends zrl now and refetches the rest
    assign rollback = item_valid && !is_dc && nonzero && (zero_run >= zrl_run);

    assign dc_category = category;

    always_comb begin
        if (rollback) begin
            ac_symbol = zrl_symbol;
        end else if (is_last && !nonzero) begin
            ac_symbol = eob_symbol;
        end else begin
            ac_symbol = {zero_run[3:0], category};
        end
    end

    //////////////////////////////
    // zero run
    always_ff @(posedge clock) begin
        if (nreset) begin
            zero_run <= '0;
        end else if (item_valid) begin
            if (rollback || is_dc || nonzero) begin
                zero_run <= '0;
            end else begin
                zero_run <= zero_run + 1'b1;
            end
        end
    end

    //////////////////////////////
    // towards the packer, in step with the rom
    always_ff @(posedge clock) begin
        if (nreset) begin
            pack_write <= 1'b0;
            pack_last  <= 1'b0;
        end else begin
            // dc, any nonzero (zrl included) or eob at the last index
            pack_write <= item_valid && (is_dc || nonzero || is_last);
            pack_last  <= item_valid && is_last && !rollback;
        end
    end

    always_ff @(posedge clock) begin
        pack_is_dc    <= is_dc;
        // zrl carries no value bits
        pack_value    <= rollback ? '0 : coded_value;
        pack_category <= rollback ? '0 : category;
    end

    // the coefficient stage drops the two items behind a rollback
    a_rollback_flush: assert property (@(posedge clock) disable iff (nreset)
        rollback |=> !item_valid ##1 !item_valid);

endmodule

// ==== sources.f ====
rtl/huff_pkg.sv
rtl/huffman_code_rom.sv
rtl/coefficient_stage.sv
rtl/run_length_stage.sv
rtl/bit_packer.sv
rtl/jpeg_huffman_encode.sv
verif/tb_jpeg_huffman_encode.sv

// ==== verif/tb_jpeg_huffman_encode.sv ====
module tb_jpeg_huffman_encode import huff_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clock_period  = 20;
    localparam int reset_cycles  = 16;
    localparam int block_count   = 17;
    localparam int watchdog_time = (reset_cycles + 8 + block_count * 200) * clock_period;

    logic      clock = 1'b0;
    logic      nreset;
    logic      start;
    coeff_t    src_data_in;
    index_t    fetch_addr;
    logic      output_wren;
    out_data_t output_data;
    out_len_t  output_length;
    logic      busy;

    coeff_t mem [0:63];
    index_t read_addr = '0;
    coeff_t prev_dc = '0;
    integer seed = 32'hf38b;

    // expected writes of all blocks, in order
    logic [31:0] exp_data [0:1023];
    out_len_t    exp_len [0:1023];
    logic        exp_known [0:1023];
    logic [9:0]  expected_total = '0;
    logic [9:0]  write_total = '0;

    int error_count = 0;
    int errors_seen = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    jpeg_huffman_encode i_jpeg_huffman_encode (
        .clock         (clock),
        .nreset        (nreset),
        .start         (start),
        .src_data_in   (src_data_in),
        .fetch_addr    (fetch_addr),
        .output_wren   (output_wren),
        .output_data   (output_data),
        .output_length (output_length),
        .busy          (busy)
    );

    always #(clock_period / 2) clock = ~clock;

    // coefficient memory, one cycle of read latency
    always @(posedge clock) begin
        #2;
        src_data_in = mem[read_addr];
        read_addr = fetch_addr;
    end

    always @(posedge clock) begin
        if (!nreset && output_wren) begin
            write_total <= write_total + 1'b1;
        end
    end

    //////////////////////////////
    // checks
    a_idle_after_reset: assert property (@(posedge clock)
        $fell(nreset) |-> !busy && !output_wren && fetch_addr == '0)
        else begin
            $display("%0d ns: outputs or fetch not idle after reset", $time);
            error_count++;
        end

    a_write_while_busy: assert property (@(posedge clock) disable iff (nreset)
        output_wren |-> busy)
        else begin
            $display("%0d ns: write strobe while busy is low", $time);
            error_count++;
        end

    a_write_expected: assert property (@(posedge clock) disable iff (nreset)
        output_wren |-> write_total < expected_total)
        else begin
            $display("%0d ns: more writes than the %0d expected", $time, expected_total);
            error_count++;
        end

    a_write_data: assert property (@(posedge clock) disable iff (nreset)
        output_wren && write_total < expected_total && exp_known[write_total]
            |-> output_data == exp_data[write_total])
        else begin
            $display("error at %0d ns: output_data is 0x%08h, expected 0x%08h", $time,
                $sampled(output_data), exp_data[$sampled(write_total)]);
            error_count++;
        end

    a_write_length: assert property (@(posedge clock) disable iff (nreset)
        output_wren && write_total < expected_total && exp_known[write_total]
            |-> output_length == exp_len[write_total])
        else begin
            $display("error at %0d ns: output_length is %0d, expected %0d", $time,
                $sampled(output_length), exp_len[$sampled(write_total)]);
            error_count++;
        end

    a_busy_after_start: assert property (@(posedge clock) disable iff (nreset)
        start |=> busy)
        else begin
            $display("%0d ns: busy did not rise after start", $time);
            error_count++;
        end

    a_busy_holds: assert property (@(posedge clock) disable iff (nreset)
        busy && !output_wren |=> busy)
        else begin
            $display("%0d ns: busy dropped before the last write", $time);
            error_count++;
        end

    a_block_complete: assert property (@(posedge clock) disable iff (nreset)
        $fell(busy) |-> write_total == expected_total)
        else begin
            $display("%0d ns: block ended after %0d writes, %0d expected", $time,
                $sampled(write_total), expected_total);
            error_count++;
        end

    //////////////////////////////
    // reference model
    function automatic int magnitude_bits(input int v);
        int mag;
        int n;
        mag = (v < 0) ? -v : v;
        n = 0;
        while (mag != 0) begin
            n++;
            mag = mag >> 1;
        end
        return n;
    endfunction

    // negative values are sent as value minus one, cut to n bits
    function automatic logic [15:0] value_bits(input int v, input int n);
        int raw;
        raw = (v < 0) ? v - 1 : v;
        return 16'(raw & ((1 << n) - 1));
    endfunction

    // a few luminance codes, zero length when not known here
    function automatic int known_code(input logic is_dc, input logic [7:0] key,
                                      output logic [15:0] code);
        int len;
        code = 16'h0000;
        len = 0;
        case ({is_dc, key})
            9'h100: len = 2;
            9'h103: begin
                code = 16'h0004;
                len = 3;
            end
            9'h000: begin
                code = 16'h000a;
                len = 4;
            end
            9'h001: len = 2;
            9'h041: begin
                code = 16'h003b;
                len = 6;
            end
            9'h0f0: begin
                code = 16'h07f9;
                len = 11;
            end
            default: len = 0;
        endcase
        return len;
    endfunction

    task automatic add_write(input logic is_dc, input logic [7:0] key, input int n,
                             input logic [15:0] bits);
        logic [15:0] code;
        int len;
        len = known_code(is_dc, key, code);
        exp_known[expected_total] = (len != 0);
        exp_data[expected_total] = {16'h0000, code} | ({16'h0000, bits} << len);
        exp_len[expected_total] = out_len_t'(len + n);
        expected_total = expected_total + 1'b1;
    endtask

    task automatic model_block();
        int diff;
        int run;
        int n;
        int v;
        diff = int'(mem[0]) - int'(prev_dc);
        n = magnitude_bits(diff);
        add_write(1'b1, 8'(n), n, value_bits(diff, n));
        prev_dc = mem[0];
        run = 0;
        for (int i = 1; i < 64; i++) begin
            v = int'(mem[index_t'(i)]);
            if (v == 0) begin
                run++;
                // end of block
                if (i == 63) begin
                    add_write(1'b0, 8'h00, 0, 16'h0000);
                end
            end else begin
                while (run >= 16) begin
                    add_write(1'b0, 8'hf0, 0, 16'h0000);
                    run -= 16;
                end
                n = magnitude_bits(v);
                add_write(1'b0, {4'(run), 4'(n)}, n, value_bits(v, n));
                run = 0;
            end
        end
    endtask

    //////////////////////////////
    // stimulus
    task automatic step();
        @(posedge clock);
        #2;
    endtask

    task automatic set_coeff(input int pos, input int value);
        mem[index_t'(pos)] = coeff_t'(value);
    endtask

    task automatic clear_block(input int dc);
        for (int i = 0; i < 64; i++) begin
            set_coeff(i, 0);
        end
        set_coeff(0, dc);
    endtask

    task automatic fill_random(input int density);
        clear_block($random(seed) % 1000);
        for (int i = 1; i < 64; i++) begin
            if (($random(seed) & 7) < density) begin
                set_coeff(i, $random(seed) % 16);
            end
        end
    endtask

    task automatic run_block();
        model_block();
        start = 1'b1;
        step();
        start = 1'b0;
        while (busy) begin
            step();
        end
        // let the end of block checks see the falling busy
        step();
        step();
    endtask

    task automatic report_test(input string name);
        if (error_count == errors_seen) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_seen);
        end
        errors_seen = error_count;
    endtask

    initial begin
        nreset = 1'b1;
        start = 1'b0;
        src_data_in = '0;
        clear_block(0);
        repeat (reset_cycles) step();
        nreset = 1'b0;
        repeat (4) step();
        report_test("reset state");

        clear_block(0);
        run_block();
        report_test("all-zero block");

        clear_block(5);
        run_block();
        run_block();
        report_test("dc prediction");

        clear_block(5);
        set_coeff(1, 1);
        run_block();
        set_coeff(1, -1);
        run_block();
        report_test("single ac values");

        clear_block(5);
        set_coeff(21, 1);
        set_coeff(22, -1);
        run_block();
        // forty zeros need two zrl symbols
        clear_block(5);
        set_coeff(41, 2);
        run_block();
        report_test("zero run length");

        clear_block(-7);
        set_coeff(3, 4);
        set_coeff(63, -3);
        run_block();
        clear_block(12);
        for (int i = 1; i < 64; i++) begin
            set_coeff(i, i % 7 - 3);
        end
        run_block();
        report_test("last coefficient nonzero");

        for (int k = 0; k < 8; k++) begin
            fill_random(1 + k % 4);
            run_block();
        end
        report_test("random blocks");

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
            tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_time);
        $display("watchdog: the run did not finish within %0d ns", watchdog_time);
        $display("TEST FAIL");
        $finish;
    end

endmodule
